/* design/imuldiv_consts.svh */
/*
  sizing constants for the multiply/divide unit
  included by the package and by any module that needs a width or a depth
*/

`ifndef IMULDIV_CONSTS_SVH
`define IMULDIV_CONSTS_SVH

// operand and single-word result width
`define IMULDIV_XLEN 32

// shift iterations per operation, one per operand bit
`define IMULDIV_ITERS 32

// router tag queue entries
// one per unit, since each unit holds one operation
`define IMULDIV_ORDER_DEPTH 2

`endif

/* design/imuldiv_pkg.sv */
/*
  shared types for the multiply/divide unit, used by the RTL and the testbench
  referenced as imuldiv_pkg::name
*/

`default_nettype none

`include "imuldiv_consts.svh"

package imuldiv_pkg;

  // operand or 32-bit result
  typedef logic [`IMULDIV_XLEN-1:0] word_t;

  // response result, full product or zero-extended word
  typedef logic [2*`IMULDIV_XLEN-1:0] dword_t;

  // iteration counter, counts down to zero
  typedef logic [$clog2(`IMULDIV_ITERS)-1:0] count_t;

  // request function codes
  typedef enum logic [2:0] {
    FN_MUL  = 3'd0,
    FN_DIV  = 3'd1,
    FN_DIVU = 3'd2,
    FN_REM  = 3'd3,
    FN_REMU = 3'd4
  } fn_t;

  // owner of a request, kept in the router's tag queue
  typedef enum logic {
    UNIT_MUL = 1'b0,
    UNIT_DIV = 1'b1
  } unit_t;

  // unit FSM states, ST_FIX only used by the divider
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_FIX  = 2'd2,
    ST_DONE = 2'd3
  } iter_state_t;

endpackage

`default_nettype wire

/* design/imuldiv_int_mul_iterative.sv */
/*
  iterative signed 32x32 multiplier with a full 64-bit product
  one shift-add step per cycle, val/rdy on both request and response
*/

`timescale 1ns/10ps
`default_nettype none

`include "imuldiv_consts.svh"

module imuldiv_int_mul_iterative (
  input  wire                   clk,
  input  wire                   reset,

  input  imuldiv_pkg::word_t    a,
  input  imuldiv_pkg::word_t    b,
  input  wire                   req_val,
  output logic                  req_rdy,

  output imuldiv_pkg::dword_t   result,
  output logic                  resp_val,
  input  wire                   resp_rdy
);

  // --------------------------------------------------
  // state and datapath registers
  // --------------------------------------------------

  imuldiv_pkg::iter_state_t state;
  imuldiv_pkg::count_t      count;

  // registered response valid, set on the last calc edge
  logic                     resp_val_r;

  // operand signs captured at acceptance
  logic                     sign_a;
  logic                     sign_b;

  // a magnitude, shifts left one place per step
  imuldiv_pkg::dword_t      a_shift;
  // b magnitude, shifts right, low bit picks the add
  imuldiv_pkg::word_t       b_shift;
  // unsigned running product
  imuldiv_pkg::dword_t      prod;

  // operand magnitudes for loading
  imuldiv_pkg::word_t       mag_a;
  imuldiv_pkg::word_t       mag_b;

  logic                     req_go;
  logic                     resp_go;

  // --------------------------------------------------
  // combinational
  // --------------------------------------------------

  assign mag_a = a[`IMULDIV_XLEN-1] ? (~a + 1'b1) : a;
  assign mag_b = b[`IMULDIV_XLEN-1] ? (~b + 1'b1) : b;

  // only take a new request when idle
  assign req_rdy  = (state == imuldiv_pkg::ST_IDLE);
  assign resp_val = resp_val_r;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // product gets its sign back when exactly one operand was negative
  assign result = (sign_a ^ sign_b) ? (~prod + 1'b1) : prod;

  // --------------------------------------------------
  // control FSM
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= imuldiv_pkg::ST_IDLE;
      count      <= '0;
      resp_val_r <= 1'b0;
    end else begin
      case (state)
        imuldiv_pkg::ST_IDLE: begin
          if (req_go) begin
            state <= imuldiv_pkg::ST_CALC;
            count <= imuldiv_pkg::count_t'(`IMULDIV_ITERS - 1);
          end
        end
        imuldiv_pkg::ST_CALC: begin
          // count reaches zero on the last of the 32 steps
          if (count == '0) begin
            state      <= imuldiv_pkg::ST_DONE;
            resp_val_r <= 1'b1;
          end else begin
            count <= count - 1'b1;
          end
        end
        imuldiv_pkg::ST_DONE: begin
          // hold the product until the consumer takes it
          if (resp_go) begin
            state      <= imuldiv_pkg::ST_IDLE;
            resp_val_r <= 1'b0;
          end
        end
        default: begin
          state      <= imuldiv_pkg::ST_IDLE;
          resp_val_r <= 1'b0;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // shift-add datapath
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      sign_a  <= a[`IMULDIV_XLEN-1];
      sign_b  <= b[`IMULDIV_XLEN-1];
      a_shift <= {{`IMULDIV_XLEN{1'b0}}, mag_a};
      b_shift <= mag_b;
      prod    <= '0;
    end else if (state == imuldiv_pkg::ST_CALC) begin
      // partial product only when this bit of b is set
      if (b_shift[0]) begin
        prod <= prod + a_shift;
      end
      a_shift <= a_shift << 1;
      b_shift <= b_shift >> 1;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // valid flag and FSM must agree on when a product is held
  a_resp_val_in_done: assert property (
    @(posedge clk) disable iff (reset)
    resp_val |-> (state == imuldiv_pkg::ST_DONE)
  );

endmodule

`default_nettype wire

/* design/imuldiv_int_div_iterative.sv */
/*
  iterative restoring divider for signed and unsigned divide and remainder
  32 shift-subtract steps then one sign fix-up step, val/rdy handshakes
*/

`timescale 1ns/10ps
`default_nettype none

`include "imuldiv_consts.svh"

module imuldiv_int_div_iterative (
  input  wire                   clk,
  input  wire                   reset,

  input  imuldiv_pkg::fn_t      fn,
  input  imuldiv_pkg::word_t    a,
  input  imuldiv_pkg::word_t    b,
  input  wire                   req_val,
  output logic                  req_rdy,

  output imuldiv_pkg::dword_t   result,
  output logic                  resp_val,
  input  wire                   resp_rdy
);

  // --------------------------------------------------
  // state and datapath registers
  // --------------------------------------------------

  imuldiv_pkg::iter_state_t state;
  imuldiv_pkg::count_t      count;
  logic                     resp_val_r;

  // operation flags captured at acceptance
  logic                     is_rem;
  logic                     neg_quot;
  logic                     neg_rem;
  logic                     div_zero;

  // quotient shifts in from the right as the dividend shifts out
  imuldiv_pkg::word_t       quot;
  // partial remainder
  imuldiv_pkg::word_t       rem;
  // divisor magnitude
  imuldiv_pkg::word_t       dvs;
  // fixed-up quotient or remainder
  imuldiv_pkg::word_t       result_r;

  // --------------------------------------------------
  // request decode and magnitudes
  // --------------------------------------------------

  logic                     fn_signed;
  logic                     fn_rem;
  logic                     sign_a;
  logic                     sign_b;
  imuldiv_pkg::word_t       mag_a;
  imuldiv_pkg::word_t       mag_b;
  logic                     req_go;
  logic                     resp_go;

  assign fn_signed = (fn == imuldiv_pkg::FN_DIV) || (fn == imuldiv_pkg::FN_REM);
  assign fn_rem    = (fn == imuldiv_pkg::FN_REM) || (fn == imuldiv_pkg::FN_REMU);

  // unsigned ops treat the top bit as magnitude
  assign sign_a = fn_signed && a[`IMULDIV_XLEN-1];
  assign sign_b = fn_signed && b[`IMULDIV_XLEN-1];
  assign mag_a  = sign_a ? (~a + 1'b1) : a;
  assign mag_b  = sign_b ? (~b + 1'b1) : b;

  assign req_rdy  = (state == imuldiv_pkg::ST_IDLE);
  assign resp_val = resp_val_r;
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;

  // divide results live in the low word
  assign result = {{`IMULDIV_XLEN{1'b0}}, result_r};

  // --------------------------------------------------
  // restoring step and fix-up
  // --------------------------------------------------

  // rem is below dvs, so the shifted value fits in 33 bits
  logic [`IMULDIV_XLEN:0]   shifted;
  logic [`IMULDIV_XLEN:0]   diff;
  logic                     fits;
  imuldiv_pkg::word_t       quot_fix;
  imuldiv_pkg::word_t       rem_fix;

  assign shifted = {rem, quot[`IMULDIV_XLEN-1]};
  assign diff    = shifted - {1'b0, dvs};
  assign fits    = (shifted >= {1'b0, dvs});

  // zero divisor forces all ones, overflow already comes out as the dividend
  assign quot_fix = div_zero ? '1 : (neg_quot ? (~quot + 1'b1) : quot);
  // remainder follows the dividend sign
  assign rem_fix  = neg_rem ? (~rem + 1'b1) : rem;

  // --------------------------------------------------
  // control FSM
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= imuldiv_pkg::ST_IDLE;
      count      <= '0;
      resp_val_r <= 1'b0;
    end else begin
      case (state)
        imuldiv_pkg::ST_IDLE: begin
          if (req_go) begin
            state <= imuldiv_pkg::ST_CALC;
            count <= imuldiv_pkg::count_t'(`IMULDIV_ITERS - 1);
          end
        end
        imuldiv_pkg::ST_CALC: begin
          if (count == '0) begin
            state <= imuldiv_pkg::ST_FIX;
          end else begin
            count <= count - 1'b1;
          end
        end
        imuldiv_pkg::ST_FIX: begin
          state      <= imuldiv_pkg::ST_DONE;
          resp_val_r <= 1'b1;
        end
        imuldiv_pkg::ST_DONE: begin
          if (resp_go) begin
            state      <= imuldiv_pkg::ST_IDLE;
            resp_val_r <= 1'b0;
          end
        end
        default: begin
          state <= imuldiv_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      is_rem   <= fn_rem;
      neg_quot <= sign_a ^ sign_b;
      neg_rem  <= sign_a;
      div_zero <= (b == '0);
      quot     <= mag_a;
      rem      <= '0;
      dvs      <= mag_b;
    end else if (state == imuldiv_pkg::ST_CALC) begin
      // subtract when the divisor fits, else restore by keeping the shift
      rem  <= fits ? diff[`IMULDIV_XLEN-1:0] : shifted[`IMULDIV_XLEN-1:0];
      quot <= {quot[`IMULDIV_XLEN-2:0], fits};
    end else if (state == imuldiv_pkg::ST_FIX) begin
      result_r <= is_rem ? rem_fix : quot_fix;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // every accepted divide spends exactly 32 edges in calc, then fix-up
  a_calc_length: assert property (
    @(posedge clk) disable iff (reset)
    req_go |=> (state == imuldiv_pkg::ST_CALC) [*`IMULDIV_ITERS]
               ##1 (state == imuldiv_pkg::ST_FIX)
  );

endmodule

`default_nettype wire

/* design/imuldiv_router.sv */
/*
  steers each request to the multiplier or divider and returns responses
  in acceptance order, using a small queue of unit tags
*/

`timescale 1ns/10ps
`default_nettype none

`include "imuldiv_consts.svh"

module imuldiv_router (
  input  wire                   clk,
  input  wire                   reset,

  input  imuldiv_pkg::fn_t      req_fn,
  input  wire                   req_val,
  output logic                  req_rdy,

  output logic                  mul_req_val,
  input  wire                   mul_req_rdy,
  output logic                  div_req_val,
  input  wire                   div_req_rdy,

  input  imuldiv_pkg::dword_t   mul_result,
  input  wire                   mul_resp_val,
  output logic                  mul_resp_rdy,
  input  imuldiv_pkg::dword_t   div_result,
  input  wire                   div_resp_val,
  output logic                  div_resp_rdy,

  output imuldiv_pkg::dword_t   resp_result,
  output logic                  resp_val,
  input  wire                   resp_rdy
);

  localparam int DEPTH = `IMULDIV_ORDER_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // --------------------------------------------------
  // tag queue
  // --------------------------------------------------

  imuldiv_pkg::unit_t       tag_q [DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [CNT_W-1:0]         count;

  imuldiv_pkg::unit_t       req_unit;
  imuldiv_pkg::unit_t       head;
  logic                     push;
  logic                     pop;
  logic                     mul_in_q;
  logic                     div_in_q;

  // request side: multiplies to the multiplier, all else to the divider
  assign req_unit = (req_fn == imuldiv_pkg::FN_MUL) ? imuldiv_pkg::UNIT_MUL
                                                    : imuldiv_pkg::UNIT_DIV;
  assign mul_req_val = req_val && (req_unit == imuldiv_pkg::UNIT_MUL);
  assign div_req_val = req_val && (req_unit == imuldiv_pkg::UNIT_DIV);
  assign req_rdy     = (req_unit == imuldiv_pkg::UNIT_MUL) ? mul_req_rdy : div_req_rdy;

  // response side: only the unit at the head may talk
  assign head        = tag_q[rd_ptr];
  assign resp_val    = (count != '0) &&
                       ((head == imuldiv_pkg::UNIT_MUL) ? mul_resp_val : div_resp_val);
  assign resp_result = (head == imuldiv_pkg::UNIT_MUL) ? mul_result : div_result;

  assign mul_resp_rdy = resp_rdy && (count != '0) && (head == imuldiv_pkg::UNIT_MUL);
  assign div_resp_rdy = resp_rdy && (count != '0) && (head == imuldiv_pkg::UNIT_DIV);

  assign push = req_val && req_rdy;
  assign pop  = resp_val && resp_rdy;

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      tag_q[wr_ptr] <= req_unit;
    end
  end

  // which units currently own a live entry
  always_comb begin
    logic [PTR_W-1:0] idx;
    mul_in_q = 1'b0;
    div_in_q = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      idx = rd_ptr + PTR_W'(i);
      if (CNT_W'(i) < count) begin
        if (tag_q[idx] == imuldiv_pkg::UNIT_MUL) begin
          mul_in_q = 1'b1;
        end else begin
          div_in_q = 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  a_no_push_full: assert property (
    @(posedge clk) disable iff (reset) push |-> (count < CNT_W'(DEPTH))
  );

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (reset) pop |-> (count != '0)
  );

  // a unit only answers for a request the router handed it
  a_mul_owned: assert property (
    @(posedge clk) disable iff (reset) mul_resp_val |-> mul_in_q
  );

  a_div_owned: assert property (
    @(posedge clk) disable iff (reset) div_resp_val |-> div_in_q
  );

endmodule

`default_nettype wire

/* design/imuldiv_top.sv */
/*
  multiply/divide unit top level
  router in front of the iterative multiplier and divider
*/

`timescale 1ns/10ps
`default_nettype none

module imuldiv_top (
  input  wire                   clk,
  input  wire                   reset,

  input  imuldiv_pkg::fn_t      req_fn,
  input  imuldiv_pkg::word_t    req_a,
  input  imuldiv_pkg::word_t    req_b,
  input  wire                   req_val,
  output logic                  req_rdy,

  output imuldiv_pkg::dword_t   resp_result,
  output logic                  resp_val,
  input  wire                   resp_rdy
);

  // unit handshakes
  logic                 mul_req_val;
  logic                 mul_req_rdy;
  logic                 div_req_val;
  logic                 div_req_rdy;

  // unit responses
  imuldiv_pkg::dword_t  mul_result;
  logic                 mul_resp_val;
  logic                 mul_resp_rdy;
  imuldiv_pkg::dword_t  div_result;
  logic                 div_resp_val;
  logic                 div_resp_rdy;

  imuldiv_router router (
    .clk          (clk),
    .reset        (reset),
    .req_fn       (req_fn),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .mul_result   (mul_result),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .div_result   (div_result),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy),
    .resp_result  (resp_result),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy)
  );

  // operands fan out to both units, only the selected one sees req_val
  imuldiv_int_mul_iterative mul (
    .clk      (clk),
    .reset    (reset),
    .a        (req_a),
    .b        (req_b),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .result   (mul_result),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  imuldiv_int_div_iterative div (
    .clk      (clk),
    .reset    (reset),
    .fn       (req_fn),
    .a        (req_a),
    .b        (req_b),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .result   (div_result),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

endmodule

`default_nettype wire

/* sim/imuldiv_tb.sv */
/*
  testbench for the multiply/divide unit: directed and random requests
  a model queue holds expected results, assertions compare them in order
*/

`timescale 1ns/10ps
`default_nettype none

module imuldiv_tb;

  localparam int CLK_PERIOD = 40;
  localparam int N_DIRECTED = 24;
  localparam int N_RANDOM   = 200;
  localparam int N_OPS      = N_DIRECTED + N_RANDOM;
  localparam int MAX_CYCLES = N_OPS * 40 + 200;

  logic                 clk;
  logic                 reset;
  imuldiv_pkg::fn_t     req_fn;
  imuldiv_pkg::word_t   req_a;
  imuldiv_pkg::word_t   req_b;
  logic                 req_val;
  logic                 req_rdy;
  imuldiv_pkg::dword_t  resp_result;
  logic                 resp_val;
  logic                 resp_rdy;

  int                   seed = 32'h1fae_1328;
  int                   rdy_seed = 32'h1fae_1328;
  int                   errors = 0;
  int                   checks = 0;
  int                   cycle_count = 0;
  logic                 bp_mode;

  // expected results in acceptance order
  imuldiv_pkg::dword_t  exp_q [$];
  imuldiv_pkg::dword_t  exp_head;
  int                   exp_count;

  imuldiv_top dut (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------

  // full signed product, or a 32-bit divide result zero-extended
  function automatic imuldiv_pkg::dword_t expected_result(input imuldiv_pkg::fn_t fn,
      input imuldiv_pkg::word_t a, input imuldiv_pkg::word_t b);
    logic        overflow;
    logic [31:0] word;
    longint      prod;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    word = '0;
    prod = longint'(signed'(a)) * longint'(signed'(b));
    case (fn)
      imuldiv_pkg::FN_MUL:  return imuldiv_pkg::dword_t'(prod);
      imuldiv_pkg::FN_DIV: begin
        if (b == '0) word = '1;
        else if (overflow) word = a;
        else word = signed'(a) / signed'(b);
      end
      imuldiv_pkg::FN_DIVU: begin
        if (b == '0) word = '1;
        else word = a / b;
      end
      imuldiv_pkg::FN_REM: begin
        // remainder keeps the sign of the dividend
        if (b == '0) word = a;
        else if (overflow) word = '0;
        else word = signed'(a) % signed'(b);
      end
      imuldiv_pkg::FN_REMU: begin
        if (b == '0) word = a;
        else word = a % b;
      end
      default: word = '0;
    endcase
    return {32'h0, word};
  endfunction

  // push on every accepted request, pop on every consumed response
  always @(posedge clk) begin
    if (reset) begin
      exp_q.delete();
    end else begin
      if (resp_val && resp_rdy && exp_q.size() != 0) begin
        exp_q.delete(0);
        checks++;
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(expected_result(req_fn, req_a, req_b));
      end
    end
    exp_count <= exp_q.size();
    exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  a_resp_match: assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> (resp_result == exp_head)
  ) else begin
    errors++;
    $display("FAIL at %0t: resp_result expected %h got %h",
             $time, $sampled(exp_head), $sampled(resp_result));
  end

  // a response with nothing outstanding is a duplicate
  a_resp_owed: assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> (exp_count != 0)
  ) else begin
    errors++;
    $display("ERROR at %0t: response consumed with no request outstanding", $time);
  end

  a_resp_stable: assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result))
  ) else begin
    errors++;
    $display("ERROR at %0t: response dropped or changed while stalled", $time);
  end

  a_reset_state: assert property (
    @(posedge clk) reset |=> (req_rdy && !resp_val)
  ) else begin
    errors++;
    $display("ERROR at %0t: req_rdy low or resp_val high after reset", $time);
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  // hold the request from a falling edge until the DUT accepts it
  task automatic issue(input imuldiv_pkg::fn_t fn, input logic [31:0] a,
                       input logic [31:0] b);
    @(negedge clk);
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
  endtask

  task automatic wait_drained();
    @(negedge clk);
    req_val = 1'b0;
    while (exp_count != 0) @(posedge clk);
  endtask

  // resp_rdy low for random stretches when back-pressure is on
  initial begin
    int r;
    int stall_left;
    resp_rdy = 1'b1;
    stall_left = 0;
    forever begin
      @(negedge clk);
      if (!bp_mode) begin
        resp_rdy = 1'b1;
      end else if (stall_left != 0) begin
        stall_left--;
      end else begin
        r = $random(rdy_seed);
        resp_rdy = ((r & 7) != 0);
        if ((r & 7) == 0) stall_left = (r >> 4) & 7;
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] ra;
    logic [31:0] rb;
    reset   = 1'b1;
    req_val = 1'b0;
    req_fn  = imuldiv_pkg::FN_MUL;
    req_a   = '0;
    req_b   = '0;
    bp_mode = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // signed multiplies, all four sign pairs plus corners
    issue(imuldiv_pkg::FN_MUL, 32'd7, 32'd6);
    issue(imuldiv_pkg::FN_MUL, -32'sd7, 32'd6);
    issue(imuldiv_pkg::FN_MUL, 32'd7, -32'sd6);
    issue(imuldiv_pkg::FN_MUL, -32'sd7, -32'sd6);
    issue(imuldiv_pkg::FN_MUL, 32'd0, 32'd12345);
    issue(imuldiv_pkg::FN_MUL, 32'h8000_0000, 32'h8000_0000);
    issue(imuldiv_pkg::FN_MUL, 32'h7fff_ffff, 32'h7fff_ffff);

    // divide and remainder, mixed signs, zero divisor, overflow
    issue(imuldiv_pkg::FN_DIV, 32'd20, 32'd3);
    issue(imuldiv_pkg::FN_DIV, -32'sd20, 32'd3);
    issue(imuldiv_pkg::FN_DIV, 32'd20, -32'sd3);
    issue(imuldiv_pkg::FN_DIV, -32'sd20, -32'sd3);
    issue(imuldiv_pkg::FN_DIV, 32'd5, 32'd0);
    issue(imuldiv_pkg::FN_DIV, 32'h8000_0000, 32'hffff_ffff);
    issue(imuldiv_pkg::FN_DIVU, 32'd20, 32'd3);
    issue(imuldiv_pkg::FN_DIVU, 32'hffff_ffff, 32'd2);
    issue(imuldiv_pkg::FN_DIVU, 32'd5, 32'd0);
    issue(imuldiv_pkg::FN_REM, -32'sd20, 32'd3);
    issue(imuldiv_pkg::FN_REM, 32'd20, -32'sd3);
    issue(imuldiv_pkg::FN_REM, 32'd5, 32'd0);
    issue(imuldiv_pkg::FN_REM, 32'h8000_0000, 32'hffff_ffff);
    issue(imuldiv_pkg::FN_REMU, 32'hffff_ffff, 32'd7);
    issue(imuldiv_pkg::FN_REMU, 32'd5, 32'd0);
    wait_drained();

    // divide then multiply one cycle apart, divide must come back first
    issue(imuldiv_pkg::FN_DIV, 32'd1000, 32'd7);
    issue(imuldiv_pkg::FN_MUL, 32'd3, 32'd5);
    wait_drained();

    // random functions and operands under back-pressure
    bp_mode <= 1'b1;
    for (int i = 0; i < N_RANDOM; i++) begin
      r  = $random(seed);
      ra = $random(seed);
      rb = $random(seed);
      // steer some divisors to zero or small values
      if (r[7:5] == 3'd0) rb = '0;
      else if (r[7:5] == 3'd1) rb = rb & 32'hf;
      issue(imuldiv_pkg::fn_t'(r[31:8] % 5), ra, rb);
    end
    bp_mode <= 1'b0;
    wait_drained();
    repeat (4) @(posedge clk);

    $display("responses checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // run limit scales with the number of operations
  initial begin
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, %0d responses outstanding", cycle_count, exp_count);
    $display("responses checked: %0d, errors: %0d", checks, errors);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/imuldiv_pkg.sv
design/imuldiv_int_mul_iterative.sv
design/imuldiv_int_div_iterative.sv
design/imuldiv_router.sv
design/imuldiv_top.sv
sim/imuldiv_tb.sv
